// File: fp_format_pkg.sv
package fp_format_pkg;

	// ####################################################################
	// Recoded operand layout.
	// ####################################################################

	// Sign, biased exponent and fraction, from MSB down.
	localparam int fp_width = 65;
	localparam int exp_width = 12;
	localparam int frac_width = 52;

	// ####################################################################
	// Class vector from the upstream classifier.
	// ####################################################################

	localparam int class_width = 10;

	// One-hot positions inside the class vector.
	localparam int class_neg_inf = 0;
	localparam int class_neg_normal = 1;
	localparam int class_neg_subnormal = 2;
	localparam int class_neg_zero = 3;
	localparam int class_pos_zero = 4;
	localparam int class_pos_subnormal = 5;
	localparam int class_pos_normal = 6;
	localparam int class_pos_inf = 7;
	localparam int class_snan = 8;
	localparam int class_qnan = 9;

	// ####################################################################
	// Formats and biases.
	// ####################################################################

	localparam logic fmt_single = 1'b0;
	localparam logic fmt_double = 1'b1;

	localparam int bias_single = 127;
	localparam int bias_double = 1023;

	// Square root takes (exp - 2045) / 2 as its unbiased exponent.
	localparam int sqrt_exp_offset = 2045;

	// Divisor substituted for b during square root.
	// Positive sign and a zero fraction, so it never changes the sign.
	localparam logic [fp_width-1:0] sqrt_b_operand = 65'h07FF0000000000000;

endpackage

// File: fdiv_pkg.sv
package fdiv_pkg;

	// ####################################################################
	// Operations and control states.
	// ####################################################################

	typedef enum logic [1:0] {
		op_fdiv,
		op_fsqrt
	} op_t;

	typedef enum logic [1:0] {
		st_idle,
		st_iterate,
		st_normalize,
		st_done
	} state_t;

	// ####################################################################
	// Recurrence bit positions.
	// ####################################################################

	// First quotient bit produced.
	localparam logic [5:0] iter_start_div = 6'd54;
	localparam logic [5:0] iter_start_sqrt = 6'd53;

	// Last quotient bit produced, per format.
	localparam logic [5:0] iter_stop_double = 6'd0;
	localparam logic [5:0] iter_stop_single = 6'd29;

	// ####################################################################
	// Datapath widths.
	// ####################################################################

	localparam int rexp_width = 14;
	localparam int rem_width = 57;
	localparam int quot_width = 55;

	// Quotient, remainder without its sign bit, and 54 zero bits of room.
	localparam int norm_width = 165;

	localparam int mant_width = 54;
	localparam int max_shift = 54;

endpackage

// File: fdiv_unpack.sv
module fdiv_unpack (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  logic accept_i,
	input  fdiv_pkg::op_t op_i,
	input  logic fmt_i,
	input  logic [fp_format_pkg::fp_width-1:0] a_i,
	input  logic [fp_format_pkg::fp_width-1:0] b_i,
	input  logic [fp_format_pkg::class_width-1:0] class_a_i,
	input  logic [fp_format_pkg::class_width-1:0] class_b_i,
	output logic [fp_format_pkg::frac_width-1:0] frac_a_o,
	output logic [fp_format_pkg::frac_width-1:0] frac_b_o,
	output logic hidden_a_o,
	output logic is_sqrt_o,
	output logic fmt_o,
	output logic sign_o,
	output logic [fdiv_pkg::rexp_width-1:0] exponent_o,
	output logic snan_o,
	output logic qnan_o,
	output logic dbz_o,
	output logic inf_o,
	output logic zero_o
);
	import fp_format_pkg::*;
	import fdiv_pkg::*;

	logic is_sqrt;
	logic capture;
	logic [fp_width-1:0] b_eff;
	logic [class_width-1:0] cls_b;
	logic a_zero, a_inf, a_finite_nz, a_neg;
	logic b_zero, b_inf, b_finite;
	logic snan_d, qnan_d, dbz_d, inf_d, zero_d;
	logic [rexp_width-1:0] exp_a, exp_b;
	logic signed [rexp_width-1:0] sqrt_diff;
	logic [rexp_width-1:0] exp_d;

	assign capture = start_i & accept_i;
	assign is_sqrt = (op_i == op_fsqrt);

	// Square root runs as a division by a fixed operand with no class.
	assign b_eff = is_sqrt ? sqrt_b_operand : b_i;
	assign cls_b = is_sqrt ? '0 : class_b_i;

	assign exp_a = rexp_width'(a_i[fp_width-2 -: exp_width]);
	assign exp_b = rexp_width'(b_eff[fp_width-2 -: exp_width]);
	assign sqrt_diff = exp_a - rexp_width'(sqrt_exp_offset);
	assign exp_d = is_sqrt ? rexp_width'(sqrt_diff >>> 1) : exp_a - exp_b;

	always_comb begin
		a_zero = class_a_i[class_neg_zero] | class_a_i[class_pos_zero];
		a_inf = class_a_i[class_neg_inf] | class_a_i[class_pos_inf];
		a_neg = class_a_i[class_neg_inf] | class_a_i[class_neg_normal] |
			class_a_i[class_neg_subnormal];
		a_finite_nz = class_a_i[class_neg_normal] | class_a_i[class_neg_subnormal] |
			class_a_i[class_pos_subnormal] | class_a_i[class_pos_normal];
		b_zero = cls_b[class_neg_zero] | cls_b[class_pos_zero];
		b_inf = cls_b[class_neg_inf] | cls_b[class_pos_inf];
		b_finite = b_zero | cls_b[class_neg_normal] | cls_b[class_neg_subnormal] |
			cls_b[class_pos_subnormal] | cls_b[class_pos_normal];

		// Invalid operations win over a quiet NaN operand.
		snan_d = class_a_i[class_snan] | cls_b[class_snan] |
			(a_zero & b_zero) | (a_inf & b_inf);
		qnan_d = ~snan_d & (class_a_i[class_qnan] | cls_b[class_qnan]);

		inf_d = a_inf & b_finite;
		dbz_d = ~inf_d & b_zero & a_finite_nz;
		zero_d = a_zero | b_inf;

		if (is_sqrt) begin
			inf_d = inf_d | class_a_i[class_pos_inf];
			snan_d = snan_d | a_neg;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			is_sqrt_o <= 1'b0;
			fmt_o <= 1'b0;
			snan_o <= 1'b0;
			qnan_o <= 1'b0;
			dbz_o <= 1'b0;
			inf_o <= 1'b0;
			zero_o <= 1'b0;
		end else if (capture) begin
			is_sqrt_o <= is_sqrt;
			fmt_o <= fmt_i;
			snan_o <= snan_d;
			qnan_o <= qnan_d;
			dbz_o <= dbz_d;
			inf_o <= inf_d;
			zero_o <= zero_d;
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			frac_a_o <= a_i[frac_width-1:0];
			frac_b_o <= b_eff[frac_width-1:0];
			hidden_a_o <= a_i[frac_width];
			sign_o <= a_i[fp_width-1] ^ b_eff[fp_width-1];
			exponent_o <= exp_d;
		end
	end

endmodule

// File: fdiv_recurrence.sv
module fdiv_recurrence (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  logic [fp_format_pkg::frac_width-1:0] frac_a_i,
	input  logic [fp_format_pkg::frac_width-1:0] frac_b_i,
	input  logic hidden_a_i,
	input  logic is_sqrt_i,
	input  logic fmt_i,
	output logic accept_o,
	output logic norm_en_o,
	output logic ready_o,
	output logic [fdiv_pkg::quot_width-1:0] quotient_o,
	output logic [fdiv_pkg::rem_width-1:0] remainder_o
);
	import fp_format_pkg::*;
	import fdiv_pkg::*;

	state_t state_q;
	logic [5:0] count_q;
	logic first_q;
	logic ready_q;
	logic [5:0] start_bit, stop_bit, bit_idx;
	logic [quot_width-1:0] quot_q, quot_cur, quot_next;
	logic [rem_width-1:0] rem_q, rem_cur, rem_shift, rem_next;
	logic [rem_width-1:0] trial, divisor, diff;

	assign accept_o = start_i && (state_q == st_idle);
	assign norm_en_o = (state_q == st_normalize);
	assign ready_o = ready_q;
	assign quotient_o = quot_q;
	assign remainder_o = rem_q;

	assign start_bit = is_sqrt_i ? iter_start_sqrt : iter_start_div;
	assign stop_bit = (fmt_i == fmt_single) ? iter_stop_single : iter_stop_double;
	assign bit_idx = first_q ? start_bit : count_q;

	// ####################################################################
	// One quotient bit per cycle.
	// ####################################################################

	always_comb begin
		// First cycle loads the remainder from the captured dividend.
		if (first_q) begin
			rem_cur = {5'h1, frac_a_i};
			if (is_sqrt_i && !hidden_a_i) begin
				rem_cur = {rem_cur[rem_width-2:0], 1'b0};
			end
			quot_cur = '0;
		end else begin
			rem_cur = rem_q;
			quot_cur = quot_q;
		end

		// Trial root is the root so far with the current bit set.
		trial = {1'b0, quot_cur, 1'b0};
		trial[bit_idx] = 1'b1;
		divisor = is_sqrt_i ? trial : {4'h1, frac_b_i, 1'b0};

		rem_shift = {rem_cur[rem_width-2:0], 1'b0};
		diff = rem_shift - divisor;

		quot_next = quot_cur;
		rem_next = rem_shift;
		if (!diff[rem_width-1]) begin
			quot_next[bit_idx] = 1'b1;
			rem_next = diff;
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == st_iterate) begin
			quot_q <= quot_next;
			rem_q <= rem_next;
		end
	end

	// ####################################################################
	// Control.
	// ####################################################################

	always_ff @(posedge clock) begin
		if (!reset) begin
			state_q <= st_idle;
			count_q <= '0;
			first_q <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			first_q <= accept_o;
			ready_q <= (state_q == st_done);
			case (state_q)
				st_idle: begin
					if (accept_o) begin
						state_q <= st_iterate;
					end
				end
				st_iterate: begin
					if (bit_idx == stop_bit) begin
						state_q <= st_normalize;
					end else begin
						count_q <= bit_idx - 6'd1;
					end
				end
				st_normalize: state_q <= st_done;
				st_done: state_q <= st_idle;
			endcase
		end
	end

	stop_bit_bound: assert property (@(posedge clock) disable iff (!reset)
		(state_q == st_iterate) |-> (bit_idx >= stop_bit));

	ready_one_cycle: assert property (@(posedge clock) disable iff (!reset)
		ready_o |=> !ready_o);

	// A start while busy is dropped.
	start_when_idle: assert property (@(posedge clock) disable iff (!reset)
		start_i |-> (state_q == st_idle))
		else $warning("start_i raised while busy, request ignored");

endmodule

// File: fdiv_normalize.sv
module fdiv_normalize (
	input  logic clock,
	input  logic reset,
	input  logic norm_en_i,
	input  logic [fdiv_pkg::quot_width-1:0] quotient_i,
	input  logic [fdiv_pkg::rem_width-1:0] remainder_i,
	input  logic sign_i,
	input  logic [fdiv_pkg::rexp_width-1:0] exponent_i,
	input  logic fmt_i,
	output logic sign_o,
	output logic [fdiv_pkg::rexp_width-1:0] exponent_o,
	output logic [fdiv_pkg::mant_width-1:0] mantissa_o,
	output logic [2:0] grs_o
);
	import fp_format_pkg::*;
	import fdiv_pkg::*;

	localparam int pad_width = norm_width - quot_width - rem_width + 1;

	logic [norm_width-1:0] norm_vec, lead_vec, shifted;
	logic lead_shift;
	logic [rexp_width-1:0] bias;
	logic [rexp_width-1:0] exp_biased, exp_d;
	logic [5:0] shift_amt;
	logic [mant_width-1:0] mant_d;
	logic [2:0] grs_d;

	assign bias = (fmt_i == fmt_double) ? rexp_width'(bias_double) : rexp_width'(bias_single);

	always_comb begin
		// Remainder sign bit is clear after the last step.
		norm_vec = {quotient_i, remainder_i[rem_width-2:0], {pad_width{1'b0}}};
		lead_shift = ~norm_vec[norm_width-1];
		lead_vec = norm_vec << lead_shift;
		exp_biased = exponent_i + bias - rexp_width'(lead_shift);

		// Below the normal range.
		shift_amt = '0;
		exp_d = exp_biased;
		if ($signed(exp_biased) <= 0) begin
			shift_amt = 6'(max_shift);
			if ($signed(exp_biased) > -max_shift) begin
				shift_amt = 6'(14'd1 - exp_biased);
			end
			exp_d = '0;
		end
		shifted = lead_vec >> shift_amt;

		// Single keeps 24 bits, double keeps 53.
		if (fmt_i == fmt_double) begin
			mant_d = {1'b0, shifted[164:112]};
			grs_d = {shifted[111:110], |shifted[109:0]};
		end else begin
			mant_d = {30'h0, shifted[164:141]};
			grs_d = {shifted[140:139], |shifted[138:0]};
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			sign_o <= 1'b0;
			exponent_o <= '0;
			mantissa_o <= '0;
			grs_o <= '0;
		end else if (norm_en_i) begin
			sign_o <= sign_i;
			exponent_o <= exp_d;
			mantissa_o <= mant_d;
			grs_o <= grs_d;
		end
	end

	shift_bound: assert property (@(posedge clock) disable iff (!reset)
		norm_en_i |-> (shift_amt <= max_shift));

endmodule

// File: fdiv_top.sv
module fdiv_top (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  fdiv_pkg::op_t op_i,
	input  logic fmt_i,
	input  logic [fp_format_pkg::fp_width-1:0] a_i,
	input  logic [fp_format_pkg::fp_width-1:0] b_i,
	input  logic [fp_format_pkg::class_width-1:0] class_a_i,
	input  logic [fp_format_pkg::class_width-1:0] class_b_i,
	output logic ready_o,
	output logic sign_o,
	output logic [fdiv_pkg::rexp_width-1:0] exponent_o,
	output logic [fdiv_pkg::mant_width-1:0] mantissa_o,
	output logic [2:0] grs_o,
	output logic snan_o,
	output logic qnan_o,
	output logic dbz_o,
	output logic inf_o,
	output logic zero_o
);
	import fp_format_pkg::*;
	import fdiv_pkg::*;

	logic accept;
	logic norm_en;
	logic [frac_width-1:0] frac_a, frac_b;
	logic hidden_a;
	logic is_sqrt;
	logic fmt;
	logic sign;
	logic [rexp_width-1:0] exponent;
	logic [quot_width-1:0] quotient;
	logic [rem_width-1:0] remainder;

	fdiv_unpack u_unpack (
		.clock(clock), .reset(reset),
		.start_i(start_i), .accept_i(accept),
		.op_i(op_i), .fmt_i(fmt_i),
		.a_i(a_i), .b_i(b_i),
		.class_a_i(class_a_i), .class_b_i(class_b_i),
		.frac_a_o(frac_a), .frac_b_o(frac_b),
		.hidden_a_o(hidden_a), .is_sqrt_o(is_sqrt), .fmt_o(fmt),
		.sign_o(sign), .exponent_o(exponent),
		.snan_o(snan_o), .qnan_o(qnan_o), .dbz_o(dbz_o),
		.inf_o(inf_o), .zero_o(zero_o)
	);

	fdiv_recurrence u_recurrence (
		.clock(clock), .reset(reset),
		.start_i(start_i),
		.frac_a_i(frac_a), .frac_b_i(frac_b),
		.hidden_a_i(hidden_a), .is_sqrt_i(is_sqrt), .fmt_i(fmt),
		.accept_o(accept), .norm_en_o(norm_en), .ready_o(ready_o),
		.quotient_o(quotient), .remainder_o(remainder)
	);

	fdiv_normalize u_normalize (
		.clock(clock), .reset(reset),
		.norm_en_i(norm_en),
		.quotient_i(quotient), .remainder_i(remainder),
		.sign_i(sign), .exponent_i(exponent), .fmt_i(fmt),
		.sign_o(sign_o), .exponent_o(exponent_o),
		.mantissa_o(mantissa_o), .grs_o(grs_o)
	);

endmodule

// File: tb_fdiv.sv
module tb_fdiv;
	import fp_format_pkg::*;
	import fdiv_pkg::*;

	logic clock;
	logic reset;
	logic start;
	op_t op;
	logic fmt;
	logic [fp_width-1:0] a;
	logic [fp_width-1:0] b;
	logic [class_width-1:0] class_a;
	logic [class_width-1:0] class_b;

	logic ready;
	logic sign;
	logic [rexp_width-1:0] exponent;
	logic [mant_width-1:0] mantissa;
	logic [2:0] grs;
	logic snan, qnan, dbz, inf, zero;

	// One entry per golden line.
	logic [1:0] v_op[$];
	logic v_fmt[$];
	logic [fp_width-1:0] v_a[$];
	logic [fp_width-1:0] v_b[$];
	logic [class_width-1:0] v_class_a[$];
	logic [class_width-1:0] v_class_b[$];
	logic v_sign[$];
	logic [rexp_width-1:0] v_exp[$];
	logic [mant_width-1:0] v_mant[$];
	logic [2:0] v_grs[$];
	logic [4:0] v_flags[$];

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	fdiv_top DUT (
		.clock(clock), .reset(reset),
		.start_i(start), .op_i(op), .fmt_i(fmt),
		.a_i(a), .b_i(b),
		.class_a_i(class_a), .class_b_i(class_b),
		.ready_o(ready), .sign_o(sign), .exponent_o(exponent),
		.mantissa_o(mantissa), .grs_o(grs),
		.snan_o(snan), .qnan_o(qnan), .dbz_o(dbz),
		.inf_o(inf), .zero_o(zero)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// ####################################################################
	// Helpers.
	// ####################################################################

	// Iteration count per operation and format.
	function automatic int iterations(input logic [1:0] op_code, input logic dbl);
		if (op_code == 2'd1) begin
			return dbl ? 54 : 25;
		end
		return dbl ? 55 : 26;
	endfunction

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (expected == actual) else begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic load_golden;
		int fd;
		int n;
		string line;
		logic [7:0] t_op, t_fmt, t_sign, t_grs, t_flags;
		logic [fp_width-1:0] t_a, t_b;
		logic [15:0] t_ca, t_cb, t_exp;
		logic [63:0] t_mant;
		fd = $fopen("fdiv_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open fdiv_golden.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 4 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t_op, t_fmt, t_a, t_b,
				t_ca, t_cb, t_sign, t_exp, t_mant, t_grs, t_flags);
			if (n != 11) begin
				$display("Malformed golden line: %s", line);
				errors++;
				continue;
			end
			v_op.push_back(t_op[1:0]);
			v_fmt.push_back(t_fmt[0]);
			v_a.push_back(t_a);
			v_b.push_back(t_b);
			v_class_a.push_back(t_ca[class_width-1:0]);
			v_class_b.push_back(t_cb[class_width-1:0]);
			v_sign.push_back(t_sign[0]);
			v_exp.push_back(t_exp[rexp_width-1:0]);
			v_mant.push_back(t_mant[mant_width-1:0]);
			v_grs.push_back(t_grs[2:0]);
			v_flags.push_back(t_flags[4:0]);
		end
		$fclose(fd);
	endtask

	// ####################################################################
	// One operation, with an optional start pulse while busy.
	// ####################################################################

	task automatic run_vector(input int idx);
		int edges;
		logic busy_start;
		busy_start = (idx % 4 == 3);
		@(posedge clock);
		start <= 1'b1;
		op <= op_t'(v_op[idx]);
		fmt <= v_fmt[idx];
		a <= v_a[idx];
		b <= v_b[idx];
		class_a <= v_class_a[idx];
		class_b <= v_class_b[idx];
		// Start edge.
		@(posedge clock);
		start <= 1'b0;
		edges = 0;
		while (1) begin
			@(negedge clock);
			if (ready) begin
				break;
			end
			if (edges > 100) begin
				$display("ready_o never rose for vector %0d", idx);
				errors++;
				break;
			end
			@(posedge clock);
			edges++;
			if (busy_start && edges == 3) begin
				start <= 1'b1;
				op <= (v_op[idx] == 2'd0) ? op_fsqrt : op_fdiv;
				fmt <= ~v_fmt[idx];
				a <= ~v_a[idx];
				b <= ~v_b[idx];
				class_a <= class_width'(1) << class_snan;
			end else if (edges == 4) begin
				start <= 1'b0;
			end
		end
		compare("latency", 64'(iterations(v_op[idx], v_fmt[idx]) + 2), 64'(edges));
		compare("sign_o", 64'(v_sign[idx]), 64'(sign));
		compare("exponent_o", 64'(v_exp[idx]), 64'(exponent));
		compare("mantissa_o", 64'(v_mant[idx]), 64'(mantissa));
		compare("grs_o", 64'(v_grs[idx]), 64'(grs));
		compare("flags", 64'(v_flags[idx]), 64'({snan, qnan, dbz, inf, zero}));
		@(posedge clock);
		@(negedge clock);
		checks++;
		assert (!ready) else begin
			$display("ready_o stayed high longer than one cycle on vector %0d", idx);
			errors++;
		end
	endtask

	initial begin
		reset = 1'b0;
		start = 1'b0;
		op = op_fdiv;
		fmt = 1'b0;
		a = '0;
		b = '0;
		class_a = '0;
		class_b = '0;
		load_golden();
		cycle_limit = v_op.size() * 60 + 100;
		repeat (2) @(posedge clock);
		reset <= 1'b1;

		// Idle with no request.
		repeat (5) begin
			@(negedge clock);
			checks++;
			assert (!ready) else begin
				$display("ready_o rose without a start request");
				errors++;
			end
		end

		for (int i = 0; i < v_op.size(); i++) begin
			run_vector(i);
		end

		$display("Vectors: %0d, checks: %0d, errors: %0d", v_op.size(), checks, errors);
		if (errors == 0 && v_op.size() > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: fdiv_golden.txt
# op(0 div, 1 sqrt) fmt(0 single, 1 double) a b class_a class_b
# expected: sign exponent mantissa grs flags{snan,qnan,dbz,inf,zero}
0 1 03FF0000000000000 03FF0000000000000 040 040 0 03FF 10000000000000 0 00
0 1 03FF8000000000000 03FF0000000000000 040 040 0 03FF 18000000000000 0 00
0 1 03FF0000000000000 03FF8000000000000 040 040 0 03FE 15555555555555 1 00
0 1 14008000000000000 03FF0000000000000 002 040 1 0400 18000000000000 0 00
0 1 03FF0000000000000 13FF0000000000000 040 002 1 03FF 10000000000000 0 00
0 0 03FF0000000000000 03FF0000000000000 040 040 0 007F 00000000800000 0 00
0 0 03FF8000000000000 03FF0000000000000 040 040 0 007F 00000000C00000 0 00
0 0 03FF0000000000000 03FF8000000000000 040 040 0 007E 00000000AAAAAA 5 00
1 1 07FF0000000000000 00000000000000000 040 000 0 03FF 10000000000000 0 00
1 0 07FF0000000000000 00000000000000000 040 000 0 007F 00000000800000 0 00
1 1 07FE2000000000000 00000000000000000 040 000 0 03FE 18000000000000 0 00
1 0 07FE2000000000000 00000000000000000 040 000 0 007E 00000000C00000 0 00
0 1 01008000000000000 05000000000000000 040 040 0 0000 06000000000000 0 00
0 1 01008000000000000 053B0000000000000 040 040 0 0000 00000000000000 3 00
0 1 03FF0000000000000 03FF0000000000000 010 010 0 03FF 10000000000000 0 11
0 1 03FF0000000000000 03FF0000000000000 080 080 0 03FF 10000000000000 0 11
0 1 03FF0000000000000 03FF0000000000000 040 010 0 03FF 10000000000000 0 04
0 1 03FF0000000000000 03FF0000000000000 080 040 0 03FF 10000000000000 0 02
0 1 03FF0000000000000 03FF0000000000000 010 040 0 03FF 10000000000000 0 01
0 1 03FF0000000000000 03FF0000000000000 200 040 0 03FF 10000000000000 0 08
0 1 03FF0000000000000 03FF0000000000000 100 040 0 03FF 10000000000000 0 10
1 1 17FF0000000000000 00000000000000000 002 000 1 03FF 10000000000000 0 10
1 0 17FF0000000000000 00000000000000000 001 000 1 007F 00000000800000 0 10
1 1 07FF0000000000000 00000000000000000 080 000 0 03FF 10000000000000 0 02
0 0 03FF8000000000000 03FF0000000000000 040 010 0 007F 00000000C00000 0 04

// File: flist.f
fp_format_pkg.sv
fdiv_pkg.sv
fdiv_unpack.sv
fdiv_recurrence.sv
fdiv_normalize.sv
fdiv_top.sv
tb_fdiv.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_fdiv
FLIST = flist.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
